/* arcade_ctrl_top.f */
+incdir+bench
design/cabinet_pkg.sv
design/dl_settings.sv
design/player_controls.sv
design/cabinet_ports.sv
design/video_dim.sv
design/arcade_ctrl_top.sv
bench/arcade_ctrl_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the arcade control testbench with Verilator and run it.
# The result comes from the simulation log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module arcade_ctrl_top_tb \
	-f arcade_ctrl_top.f \
	-o sim_arcade_ctrl

./obj_dir/sim_arcade_ctrl | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

/* bench/tb_checks.svh */
/*
 * Testbench check helpers
 * Error counters, the stimulus LFSR and the typed compare tasks
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Totals for the closing line
int check_count = 0;
int error_count = 0;

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// ========================================
// Compare tasks
// ========================================

task automatic check_byte(input string what, input cabinet_pkg::byte_t got,
		input cabinet_pkg::byte_t want);
	check_count++;
	if (got !== want) begin
		error_count++;
		$display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, want);
	end
endtask

task automatic check_rgb(input string what, input cabinet_pkg::rgb_t got,
		input cabinet_pkg::rgb_t want);
	check_count++;
	if (got !== want) begin
		error_count++;
		$display("MISMATCH at %0t: %s got %03h expected %03h", $time, what, got, want);
	end
endtask

task automatic check_pause(input string what, input logic got, input logic want);
	check_count++;
	if (got !== want) begin
		error_count++;
		$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, want);
	end
endtask

`endif

/* bench/arcade_ctrl_top_tb.sv */
/*
 * Arcade control front end testbench
 * Directed tests for downloads, per-game mapping, pause and dimming
 */

`default_nettype none

module arcade_ctrl_top_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// Tests take roughly 500 cycles, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int unsigned DIM_CYCLES = 20;
	localparam cabinet_pkg::pad_t PAUSE_PAD = cabinet_pkg::pad_t'(1) << cabinet_pkg::PAD_PAUSE;

	logic clk_12 = 1'b0;
	logic rst;
	logic dl_wr;
	cabinet_pkg::byte_t dl_index;
	logic [cabinet_pkg::DL_ADDR_W-1:0] dl_addr;
	cabinet_pkg::byte_t dl_data;
	cabinet_pkg::pad_t pad_0;
	cabinet_pkg::pad_t pad_1;
	cabinet_pkg::rgb_t rgb_in;
	cabinet_pkg::byte_t input_0;
	cabinet_pkg::byte_t input_1;
	cabinet_pkg::byte_t input_2;
	cabinet_pkg::byte_t input_3;
	cabinet_pkg::byte_t input_4;
	logic pause;
	cabinet_pkg::rgb_t rgb_out;

	// Reference model state
	cabinet_pkg::byte_t model_game = 8'd0;
	cabinet_pkg::byte_t model_dip [3] = '{8'd0, 8'd0, 8'd0};
	cabinet_pkg::pad_t cur_pad_0 = '0;
	cabinet_pkg::pad_t cur_pad_1 = '0;
	logic model_pause = 1'b0;
	logic last_req = 1'b0;
	logic [31:0] lfsr_state = 32'd32;
	int cycle_count = 0;

	`include "tb_checks.svh"

	arcade_ctrl_top #(
		.DIM_CYCLES (DIM_CYCLES)
	) u_arcade_ctrl_top (
		.clk_12   (clk_12),
		.rst      (rst),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.pad_0    (pad_0),
		.pad_1    (pad_1),
		.rgb_in   (rgb_in),
		.input_0  (input_0),
		.input_1  (input_1),
		.input_2  (input_2),
		.input_3  (input_3),
		.input_4  (input_4),
		.pause    (pause),
		.rgb_out  (rgb_out)
	);

	// 8 ns clock
	always #4 clk_12 = ~clk_12;

	// Watchdog on the whole run
	always @(posedge clk_12) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	// Lands 1 ns past the edge, where drives and samples happen
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_12);
		#1;
	endtask

	// One LFSR step per bit taken
	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// Drives both pads and tracks the pause toggle on a new press
	task automatic apply_pads(input cabinet_pkg::pad_t p0, input cabinet_pkg::pad_t p1);
		logic req;
		req = p0[cabinet_pkg::PAD_PAUSE] | p1[cabinet_pkg::PAD_PAUSE];
		if (req && !last_req) begin
			model_pause = ~model_pause;
		end
		last_req = req;
		cur_pad_0 = p0;
		cur_pad_1 = p1;
		pad_0 = p0;
		pad_1 = p1;
	endtask

	// One-cycle write strobe, model follows the download rules
	task automatic dl_write(input cabinet_pkg::byte_t index,
			input logic [cabinet_pkg::DL_ADDR_W-1:0] addr, input cabinet_pkg::byte_t data);
		dl_wr = 1'b1;
		dl_index = index;
		dl_addr = addr;
		dl_data = data;
		wait_cycles(1);
		dl_wr = 1'b0;
		if (index == cabinet_pkg::DL_INDEX_GAME) begin
			model_game = data;
		end else if (index == cabinet_pkg::DL_INDEX_DIP &&
				addr < cabinet_pkg::DL_ADDR_W'(cabinet_pkg::DIP_COUNT)) begin
			model_dip[addr[1:0]] = data;
		end
	endtask

	// ========================================
	// Reference model
	// ========================================

	// Expected cabinet byte, built bit by bit from the mapping table
	function automatic cabinet_pkg::byte_t expect_port(input int idx);
		cabinet_pkg::byte_t b;
		logic mv_up;
		logic mv_down;
		logic mv_left;
		logic mv_right;
		logic f_up;
		logic f_down;
		logic f_left;
		logic f_right;
		logic st1;
		logic st2;
		logic coin_in;
		mv_up = cur_pad_0[cabinet_pkg::PAD_UP];
		mv_down = cur_pad_0[cabinet_pkg::PAD_DOWN];
		mv_left = cur_pad_0[cabinet_pkg::PAD_LEFT];
		mv_right = cur_pad_0[cabinet_pkg::PAD_RIGHT];
		// Second pad stick doubles as a fire stick
		f_up = cur_pad_0[cabinet_pkg::PAD_FIRE_UP] | cur_pad_1[cabinet_pkg::PAD_UP];
		f_down = cur_pad_0[cabinet_pkg::PAD_FIRE_DOWN] | cur_pad_1[cabinet_pkg::PAD_DOWN];
		f_left = cur_pad_0[cabinet_pkg::PAD_FIRE_LEFT] | cur_pad_1[cabinet_pkg::PAD_LEFT];
		f_right = cur_pad_0[cabinet_pkg::PAD_FIRE_RIGHT] | cur_pad_1[cabinet_pkg::PAD_RIGHT];
		st1 = cur_pad_0[cabinet_pkg::PAD_START1] | cur_pad_1[cabinet_pkg::PAD_START1];
		st2 = cur_pad_0[cabinet_pkg::PAD_START2] | cur_pad_1[cabinet_pkg::PAD_START2];
		coin_in = cur_pad_0[cabinet_pkg::PAD_COIN] | cur_pad_1[cabinet_pkg::PAD_COIN];
		case (idx)
			1: b = model_dip[0];
			2: b = model_dip[1];
			default: b = 8'hFF;
		endcase
		// Lunar Battle has no DIP bytes on its ports
		if (model_game == 8'd2 && (idx == 1 || idx == 2)) begin
			b = 8'hFF;
		end
		// Shared coin byte for the three mapped games
		if (idx == 0 && model_game <= 8'd2) begin
			b[6] = 1'b0;
			b[5] = ~model_dip[2][0];
			b[4] = ~model_dip[2][1];
			b[1] = ~coin_in;
		end
		if (model_game == 8'd0 && idx == 3) begin
			b[3] = ~mv_up;
			b[2] = ~mv_down;
			b[1] = ~mv_left;
			b[0] = ~mv_right;
		end else if (model_game == 8'd0 && idx == 4) begin
			b[6] = ~st2;
			b[5] = ~st1;
			b[3] = ~f_up;
			b[2] = ~f_down;
			b[1] = ~f_left;
			b[0] = ~f_right;
		end else if (model_game == 8'd1 && idx == 3) begin
			b[4] = ~f_left;
			b[3] = ~mv_left;
			b[2] = ~mv_right;
			b[1] = ~f_right;
			b[0] = ~f_down;
		end else if (model_game == 8'd1 && idx == 4) begin
			b[6] = ~st2;
			b[5] = ~st1;
		end else if (model_game == 8'd2 && idx == 3) begin
			// Lunar Battle byte is active high
			b = {1'b0, st2, st1, f_left, f_down, f_right, mv_right, mv_left};
		end
		return b;
	endfunction

	task automatic check_ports(input string tag);
		check_byte({tag, " input_0"}, input_0, expect_port(0));
		check_byte({tag, " input_1"}, input_1, expect_port(1));
		check_byte({tag, " input_2"}, input_2, expect_port(2));
		check_byte({tag, " input_3"}, input_3, expect_port(3));
		check_byte({tag, " input_4"}, input_4, expect_port(4));
	endtask

	// Random colour in, compare one cycle later
	task automatic step_rgb(input logic dimmed, input string tag);
		logic [31:0] r;
		cabinet_pkg::rgb_t col;
		cabinet_pkg::rgb_t want;
		random_bits(12, r);
		col = r[11:0];
		rgb_in = col;
		wait_cycles(1);
		want = col;
		if (dimmed) begin
			want.red = {1'b0, col.red[3:1]};
			want.green = {1'b0, col.green[3:1]};
			want.blue = {1'b0, col.blue[3:1]};
		end
		check_rgb(tag, rgb_out, want);
	endtask

	// Idle pads, and one extra press if pause was left on
	task automatic settle_pause();
		apply_pads('0, '0);
		wait_cycles(2);
		if (model_pause) begin
			apply_pads(PAUSE_PAD, '0);
			wait_cycles(2);
			apply_pads('0, '0);
			wait_cycles(2);
		end
		check_pause("pause settled", pause, 1'b0);
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic test_reset_defaults();
		check_pause("reset pause", pause, 1'b0);
		check_ports("reset");
	endtask

	task automatic test_downloads();
		dl_write(cabinet_pkg::DL_INDEX_DIP, 25'd0, 8'h5A);
		wait_cycles(1);
		check_ports("dip_0 write");
		dl_write(cabinet_pkg::DL_INDEX_DIP, 25'd1, 8'hC3);
		wait_cycles(1);
		check_ports("dip_1 write");
		dl_write(cabinet_pkg::DL_INDEX_DIP, 25'd2, 8'h02);
		wait_cycles(1);
		check_ports("dip_2 write");
		dl_write(cabinet_pkg::DL_INDEX_DIP, 25'd2, 8'h01);
		wait_cycles(1);
		check_ports("dip_2 rewrite");
		// Neither of these may change anything
		dl_write(cabinet_pkg::DL_INDEX_DIP, 25'd5, 8'hEE);
		wait_cycles(1);
		check_ports("dip address 5");
		dl_write(8'h07, 25'd0, 8'h99);
		wait_cycles(1);
		check_ports("unrelated index");
	endtask

	task automatic test_game_mapping(input cabinet_pkg::byte_t game_byte);
		logic [31:0] r0;
		logic [31:0] r1;
		dl_write(cabinet_pkg::DL_INDEX_GAME, 25'd0, game_byte);
		wait_cycles(1);
		check_ports($sformatf("game %0d select", game_byte));
		for (int i = 0; i < 30; i++) begin
			random_bits(12, r0);
			random_bits(12, r1);
			apply_pads(r0[11:0], r1[11:0]);
			wait_cycles(2);
			check_ports($sformatf("game %0d pads %0d", game_byte, i));
			check_pause("mapping pause", pause, model_pause);
		end
	endtask

	task automatic test_pause_toggle();
		settle_pause();
		apply_pads('0, PAUSE_PAD);
		wait_cycles(1);
		check_pause("pause press, 1 cycle", pause, 1'b0);
		wait_cycles(1);
		check_pause("pause press, 2 cycles", pause, 1'b1);
		// Holding the button must not flip it again
		repeat (5) begin
			wait_cycles(1);
			check_pause("pause held", pause, 1'b1);
		end
		apply_pads('0, '0);
		wait_cycles(2);
		check_pause("pause released", pause, 1'b1);
		apply_pads('0, PAUSE_PAD);
		wait_cycles(2);
		check_pause("second press", pause, 1'b0);
		apply_pads('0, '0);
		wait_cycles(2);
	endtask

	task automatic test_dimming();
		settle_pause();
		repeat (5) step_rgb(1'b0, "running colour");
		apply_pads(PAUSE_PAD, '0);
		step_rgb(1'b0, "pause pressed");
		step_rgb(1'b0, "pause rising");
		check_pause("dim pause high", pause, 1'b1);
		step_rgb(1'b0, "just paused");
		// Timeout runs out during this wait
		apply_pads('0, '0);
		wait_cycles(23);
		step_rgb(1'b1, "dimmed");
		step_rgb(1'b1, "still dimmed");
		apply_pads(PAUSE_PAD, '0);
		step_rgb(1'b1, "unpause pressed");
		step_rgb(1'b1, "unpause edge");
		check_pause("dim pause low", pause, 1'b0);
		step_rgb(1'b0, "brightness back");
		apply_pads('0, '0);
		repeat (2) step_rgb(1'b0, "running again");
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		rst = 1'b1;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		pad_0 = '0;
		pad_1 = '0;
		rgb_in = '0;
		repeat (3) @(posedge clk_12);
		#1;
		rst = 1'b0;
		test_reset_defaults();
		test_downloads();
		test_game_mapping(8'd0);
		test_game_mapping(8'd1);
		test_game_mapping(8'd2);
		test_game_mapping(8'd3);
		test_game_mapping(8'd7);
		test_pause_toggle();
		test_dimming();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/arcade_ctrl_top.sv */
/*
 * Arcade control front end
 * Download settings, player controls, cabinet input bytes
 * and the pause dimmer on one clock
 */

`default_nettype none

module arcade_ctrl_top #(
	parameter int unsigned DIM_CYCLES = 120_000_000
) (
	input  wire                                 clk_12,
	input  wire                                 rst,
	input  wire                                 dl_wr,
	input  wire cabinet_pkg::byte_t             dl_index,
	input  wire [cabinet_pkg::DL_ADDR_W-1:0]    dl_addr,
	input  wire cabinet_pkg::byte_t             dl_data,
	input  wire cabinet_pkg::pad_t              pad_0,
	input  wire cabinet_pkg::pad_t              pad_1,
	input  wire cabinet_pkg::rgb_t              rgb_in,
	output cabinet_pkg::byte_t                  input_0,
	output cabinet_pkg::byte_t                  input_1,
	output cabinet_pkg::byte_t                  input_2,
	output cabinet_pkg::byte_t                  input_3,
	output cabinet_pkg::byte_t                  input_4,
	output logic                                pause,
	output cabinet_pkg::rgb_t                   rgb_out
);

	// Settings to the port mapper
	cabinet_pkg::game_t game;
	cabinet_pkg::byte_t dip_0;
	cabinet_pkg::byte_t dip_1;
	cabinet_pkg::byte_t dip_2;

	// Merged controls
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire_up;
	logic fire_down;
	logic fire_left;
	logic fire_right;
	logic start1;
	logic start2;
	logic coin;

	// ========================================
	// Settings and controls, side by side
	// ========================================

	dl_settings u_dl_settings (
		.clk_12   (clk_12),
		.rst      (rst),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip_0    (dip_0),
		.dip_1    (dip_1),
		.dip_2    (dip_2)
	);

	player_controls u_player_controls (
		.clk_12     (clk_12),
		.rst        (rst),
		.pad_0      (pad_0),
		.pad_1      (pad_1),
		.up         (up),
		.down       (down),
		.left       (left),
		.right      (right),
		.fire_up    (fire_up),
		.fire_down  (fire_down),
		.fire_left  (fire_left),
		.fire_right (fire_right),
		.start1     (start1),
		.start2     (start2),
		.coin       (coin),
		.pause      (pause)
	);

	// ========================================
	// Cabinet bytes and dimmer
	// ========================================

	cabinet_ports u_cabinet_ports (
		.clk_12     (clk_12),
		.rst        (rst),
		.game       (game),
		.dip_0      (dip_0),
		.dip_1      (dip_1),
		.dip_2      (dip_2),
		.up         (up),
		.down       (down),
		.left       (left),
		.right      (right),
		.fire_up    (fire_up),
		.fire_down  (fire_down),
		.fire_left  (fire_left),
		.fire_right (fire_right),
		.start1     (start1),
		.start2     (start2),
		.coin       (coin),
		.input_0    (input_0),
		.input_1    (input_1),
		.input_2    (input_2),
		.input_3    (input_3),
		.input_4    (input_4)
	);

	video_dim #(
		.DIM_CYCLES (DIM_CYCLES)
	) u_video_dim (
		.clk_12  (clk_12),
		.rst     (rst),
		.pause   (pause),
		.rgb_in  (rgb_in),
		.rgb_out (rgb_out)
	);

endmodule

`default_nettype wire

/* design/video_dim.sv */
/*
 * Pause screen dimmer
 * Registers the colour stream and halves each channel
 * once pause has been held for DIM_CYCLES clocks
 */

`default_nettype none

module video_dim #(
	parameter int unsigned DIM_CYCLES = 120_000_000
) (
	input  wire                      clk_12,
	input  wire                      rst,
	input  wire                      pause,
	input  wire cabinet_pkg::rgb_t   rgb_in,
	output cabinet_pkg::rgb_t        rgb_out
);

	// Counter wide enough to hold DIM_CYCLES itself
	localparam int CNT_W = $clog2(DIM_CYCLES + 1);
	localparam logic [CNT_W-1:0] DIM_LAST = CNT_W'(DIM_CYCLES);

	logic [CNT_W-1:0] dim_cnt;
	logic dim;

	// ========================================
	// Pause timer
	// ========================================

	// Saturates at DIM_LAST, clears as soon as pause drops
	always_ff @(posedge clk_12) begin
		if (rst) begin
			dim_cnt <= '0;
		end else if (!pause) begin
			dim_cnt <= '0;
		end else if (dim_cnt != DIM_LAST) begin
			dim_cnt <= dim_cnt + 1'b1;
		end
	end

	// Gated by pause so brightness returns right after unpausing
	assign dim = pause && (dim_cnt == DIM_LAST);

	// ========================================
	// Colour register
	// ========================================

	always_ff @(posedge clk_12) begin
		if (dim) begin
			rgb_out.red   <= rgb_in.red >> 1;
			rgb_out.green <= rgb_in.green >> 1;
			rgb_out.blue  <= rgb_in.blue >> 1;
		end else begin
			rgb_out <= rgb_in;
		end
	end

endmodule

`default_nettype wire

/* design/cabinet_ports.sv */
/*
 * Cabinet input ports
 * Builds the five input bytes for the selected game, in that game's
 * own bit order and polarity, and registers them
 */

`default_nettype none

module cabinet_ports (
	input  wire                      clk_12,
	input  wire                      rst,
	input  wire cabinet_pkg::game_t  game,
	input  wire cabinet_pkg::byte_t  dip_0,
	input  wire cabinet_pkg::byte_t  dip_1,
	input  wire cabinet_pkg::byte_t  dip_2,
	input  wire                      up,
	input  wire                      down,
	input  wire                      left,
	input  wire                      right,
	input  wire                      fire_up,
	input  wire                      fire_down,
	input  wire                      fire_left,
	input  wire                      fire_right,
	input  wire                      start1,
	input  wire                      start2,
	input  wire                      coin,
	output cabinet_pkg::byte_t       input_0,
	output cabinet_pkg::byte_t       input_1,
	output cabinet_pkg::byte_t       input_2,
	output cabinet_pkg::byte_t       input_3,
	output cabinet_pkg::byte_t       input_4
);

	// Idle Black Widow bytes with cleared DIPs
	localparam cabinet_pkg::byte_t IDLE_0 = 8'hBF;
	localparam cabinet_pkg::byte_t IDLE_1 = 8'h00;
	localparam cabinet_pkg::byte_t IDLE_2 = 8'h00;
	localparam cabinet_pkg::byte_t IDLE_3 = 8'hFF;
	localparam cabinet_pkg::byte_t IDLE_4 = 8'hFF;

	cabinet_pkg::byte_t nxt_0;
	cabinet_pkg::byte_t nxt_1;
	cabinet_pkg::byte_t nxt_2;
	cabinet_pkg::byte_t nxt_3;
	cabinet_pkg::byte_t nxt_4;
	cabinet_pkg::byte_t coin_port;

	// Coin and DIP port shared by all three mapped games
	// Bit 6 low, bits 5:4 inverted coin options, bit 1 coin low
	assign coin_port = {1'b1, 1'b0, ~dip_2[0], ~dip_2[1], 2'b11, ~coin, 1'b1};

	// ========================================
	// Per-game byte mapping
	// ========================================

	always_comb begin
		// Defaults, the unmapped game keeps these
		nxt_0 = 8'hFF;
		nxt_1 = dip_0;
		nxt_2 = dip_1;
		nxt_3 = 8'hFF;
		nxt_4 = 8'hFF;
		case (game)
			cabinet_pkg::GAME_BWIDOW: begin
				nxt_0 = coin_port;
				// Move stick, all low active
				nxt_3 = {4'hF, ~up, ~down, ~left, ~right};
				nxt_4 = {1'b1, ~start2, ~start1, 1'b1,
					~fire_up, ~fire_down, ~fire_left, ~fire_right};
			end
			cabinet_pkg::GAME_GRAVITAR: begin
				nxt_0 = coin_port;
				// Rotate, thrust and shields share one byte
				nxt_3 = {3'b111, ~fire_left, ~left, ~right, ~fire_right, ~fire_down};
				nxt_4 = {1'b1, ~start2, ~start1, 5'b11111};
			end
			cabinet_pkg::GAME_LUNARBAT: begin
				nxt_0 = coin_port;
				// No DIP bytes on this cabinet
				nxt_1 = 8'hFF;
				nxt_2 = 8'hFF;
				// Active high controls
				nxt_3 = {1'b0, start2, start1, fire_left, fire_down, fire_right, right, left};
			end
			default: ;
		endcase
	end

	// ========================================
	// Output registers
	// ========================================

	always_ff @(posedge clk_12) begin
		if (rst) begin
			input_0 <= IDLE_0;
			input_1 <= IDLE_1;
			input_2 <= IDLE_2;
			input_3 <= IDLE_3;
			input_4 <= IDLE_4;
		end else begin
			input_0 <= nxt_0;
			input_1 <= nxt_1;
			input_2 <= nxt_2;
			input_3 <= nxt_3;
			input_4 <= nxt_4;
		end
	end

endmodule

`default_nettype wire

/* design/player_controls.sv */
/*
 * Player controls
 * Registers both pads, merges them into one cabinet control set
 * and toggles the pause level on each new pause press
 */

`default_nettype none

module player_controls (
	input  wire                     clk_12,
	input  wire                     rst,
	input  wire cabinet_pkg::pad_t  pad_0,
	input  wire cabinet_pkg::pad_t  pad_1,
	output logic                    up,
	output logic                    down,
	output logic                    left,
	output logic                    right,
	output logic                    fire_up,
	output logic                    fire_down,
	output logic                    fire_left,
	output logic                    fire_right,
	output logic                    start1,
	output logic                    start2,
	output logic                    coin,
	output logic                    pause
);

	cabinet_pkg::pad_t pad_0_q;
	cabinet_pkg::pad_t pad_1_q;
	logic pause_req;
	logic pause_req_q;

	// ========================================
	// Pad input registers
	// ========================================

	always_ff @(posedge clk_12) begin
		if (rst) begin
			pad_0_q <= '0;
			pad_1_q <= '0;
		end else begin
			pad_0_q <= pad_0;
			pad_1_q <= pad_1;
		end
	end

	// Movement from pad 0 only
	assign up    = pad_0_q[cabinet_pkg::PAD_UP];
	assign down  = pad_0_q[cabinet_pkg::PAD_DOWN];
	assign left  = pad_0_q[cabinet_pkg::PAD_LEFT];
	assign right = pad_0_q[cabinet_pkg::PAD_RIGHT];

	// Pad 1 stick acts as a second fire stick
	assign fire_up    = pad_0_q[cabinet_pkg::PAD_FIRE_UP] | pad_1_q[cabinet_pkg::PAD_UP];
	assign fire_down  = pad_0_q[cabinet_pkg::PAD_FIRE_DOWN] | pad_1_q[cabinet_pkg::PAD_DOWN];
	assign fire_left  = pad_0_q[cabinet_pkg::PAD_FIRE_LEFT] | pad_1_q[cabinet_pkg::PAD_LEFT];
	assign fire_right = pad_0_q[cabinet_pkg::PAD_FIRE_RIGHT] | pad_1_q[cabinet_pkg::PAD_RIGHT];

	// Shared buttons, either pad
	assign start1    = pad_0_q[cabinet_pkg::PAD_START1] | pad_1_q[cabinet_pkg::PAD_START1];
	assign start2    = pad_0_q[cabinet_pkg::PAD_START2] | pad_1_q[cabinet_pkg::PAD_START2];
	assign coin      = pad_0_q[cabinet_pkg::PAD_COIN] | pad_1_q[cabinet_pkg::PAD_COIN];
	assign pause_req = pad_0_q[cabinet_pkg::PAD_PAUSE] | pad_1_q[cabinet_pkg::PAD_PAUSE];

	// ========================================
	// Pause toggle
	// ========================================

	// Only a fresh press flips pause, holding does nothing
	always_ff @(posedge clk_12) begin
		if (rst) begin
			pause_req_q <= 1'b0;
			pause <= 1'b0;
		end else begin
			pause_req_q <= pause_req;
			if (pause_req && !pause_req_q) begin
				pause <= ~pause;
			end
		end
	end

endmodule

`default_nettype wire

/* design/dl_settings.sv */
/*
 * Download settings capture
 * Picks the active game and loads the DIP bytes from download writes
 */

`default_nettype none

module dl_settings (
	input  wire                                 clk_12,
	input  wire                                 rst,
	input  wire                                 dl_wr,
	input  wire cabinet_pkg::byte_t             dl_index,
	input  wire [cabinet_pkg::DL_ADDR_W-1:0]    dl_addr,
	input  wire cabinet_pkg::byte_t             dl_data,
	output cabinet_pkg::game_t                  game,
	output cabinet_pkg::byte_t                  dip_0,
	output cabinet_pkg::byte_t                  dip_1,
	output cabinet_pkg::byte_t                  dip_2
);

	// Game byte to cabinet, Space Duel and above fall through
	function automatic cabinet_pkg::game_t decode_game(input cabinet_pkg::byte_t sel);
		case (sel)
			8'd0:    decode_game = cabinet_pkg::GAME_BWIDOW;
			8'd1:    decode_game = cabinet_pkg::GAME_GRAVITAR;
			8'd2:    decode_game = cabinet_pkg::GAME_LUNARBAT;
			default: decode_game = cabinet_pkg::GAME_UNMAPPED;
		endcase
	endfunction

	logic game_wr;
	logic dip_wr;

	// Write decode
	assign game_wr = dl_wr && (dl_index == cabinet_pkg::DL_INDEX_GAME);
	// Addresses past the stored bytes are dropped here
	assign dip_wr = dl_wr && (dl_index == cabinet_pkg::DL_INDEX_DIP) &&
		(dl_addr < cabinet_pkg::DL_ADDR_W'(cabinet_pkg::DIP_COUNT));

	always_ff @(posedge clk_12) begin
		if (rst) begin
			game <= cabinet_pkg::GAME_BWIDOW;
			dip_0 <= '0;
			dip_1 <= '0;
			dip_2 <= '0;
		end else begin
			if (game_wr) begin
				game <= decode_game(dl_data);
			end
			if (dip_wr) begin
				// Low address bits pick the DIP byte
				case (dl_addr[1:0])
					2'd0:    dip_0 <= dl_data;
					2'd1:    dip_1 <= dl_data;
					2'd2:    dip_2 <= dl_data;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/cabinet_pkg.sv */
/*
 * Cabinet control package
 * Shared types, download indexes and gamepad bit positions
 */

`default_nettype none

package cabinet_pkg;

	// ========================================
	// Basic data types
	// ========================================

	// Download data, DIP bytes and cabinet input bytes
	typedef logic [7:0] byte_t;

	// Gamepad word, every bit active high
	typedef logic [11:0] pad_t;

	// Colour stream, red in the top nibble
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	// Active cabinet, byte 3 and up have no mapping
	typedef enum logic [1:0] {
		GAME_BWIDOW   = 2'd0,
		GAME_GRAVITAR = 2'd1,
		GAME_LUNARBAT = 2'd2,
		GAME_UNMAPPED = 2'd3
	} game_t;

	// ========================================
	// Download port
	// ========================================

	localparam int DL_ADDR_W = 25;
	localparam byte_t DL_INDEX_GAME = 8'd1;
	localparam byte_t DL_INDEX_DIP = 8'd254;

	// Only the DIP bytes the mappings read
	localparam int DIP_COUNT = 3;

	// ========================================
	// Gamepad bit positions
	// ========================================

	localparam int PAD_RIGHT      = 0;
	localparam int PAD_LEFT       = 1;
	localparam int PAD_DOWN       = 2;
	localparam int PAD_UP         = 3;
	localparam int PAD_FIRE_RIGHT = 4;
	localparam int PAD_FIRE_LEFT  = 5;
	localparam int PAD_FIRE_UP    = 6;
	localparam int PAD_FIRE_DOWN  = 7;
	localparam int PAD_START1     = 8;
	localparam int PAD_START2     = 9;
	localparam int PAD_COIN       = 10;
	localparam int PAD_PAUSE      = 11;

endpackage

`default_nettype wire
